//--- bench/colseg_cases.txt
// columns in hex: test op field data expected; op 1 write, 2 read, 3 pixel, 4 vs, F end
// field is the address, the pixel de or the vs level; pixel expected is {o_de, o_pixel}
// reset defaults, read back, unused address
01 2 0 0000 0003E
01 2 3 0000 00008
01 2 B 0000 0003F
01 2 C 0000 00001
01 2 D 0000 00000
01 2 E 0000 00000
01 1 5 0030 00000
01 2 5 0000 00030
01 1 F 00AA 00000
01 2 F 0000 00000
// raw view
02 3 1 1234 11234
02 3 1 ABCD 1ABCD
02 3 0 FFFF 00000
02 3 1 F800 1F800
02 3 1 07E0 107E0
// class A ref r=2C, err 8, window 10..30
03 1 0 002C 00000
03 1 E 0001 00000
03 1 D 0001 00000
03 3 1 B000 1FFFF
03 3 1 B100 1FFFF
03 3 1 B120 10000
03 3 1 C800 10000
03 3 0 B000 00000
// both classes, then class B only
04 1 E 0003 00000
04 3 1 B000 1FFFF
04 3 1 001F 1FFFF
04 3 1 07E0 10000
04 1 E 0002 00000
04 3 1 B000 10000
04 3 1 001F 1FFFF
// keep view, erode min 2 then 3
05 1 C 0002 00000
05 1 D 0002 00000
05 3 1 0000 10000
05 3 1 001F 10000
05 3 1 0000 10000
05 3 1 001F 1001F
05 3 1 001E 1001E
05 3 1 001D 1001D
05 3 1 0000 10000
05 1 C 0003 00000
05 3 1 001F 10000
05 3 1 001E 1001E
05 3 1 001D 10000
// vs drops pixels in flight and the erosion history
06 1 C 0002 00000
06 3 1 001F 00000
06 3 1 001E 00000
06 4 1 0000 00000
06 3 1 001D 00000
06 3 1 001F 00000
06 4 0 0000 00000
06 3 1 001F 10000
06 3 1 0000 10000
06 3 1 001F 1001F
06 3 1 001F 1001F
00 F 0 0000 00000

//--- bench/tb_colseg.sv
`timescale 1ns/1ns
`include "colseg_defines.svh"

module tb_colseg;
    import colseg_pkg::*;

    localparam int MAX_RECS  = 128;
    localparam int REC_W     = 5;       // words per record
    localparam int ACK_LIMIT = 16;

    localparam logic [19:0] OP_WR  = 20'h1;
    localparam logic [19:0] OP_RD  = 20'h2;
    localparam logic [19:0] OP_PIX = 20'h3;
    localparam logic [19:0] OP_VS  = 20'h4;
    localparam logic [19:0] OP_END = 20'hF;

    logic      post_clk;
    logic      sys_rst_n;
    logic      i_wb_cyc;
    logic      i_wb_stb;
    logic      i_wb_we;
    reg_addr_t i_wb_adr;
    reg_t      i_wb_dat;
    reg_t      o_wb_dat;
    logic      o_wb_ack;
    logic      i_vs;
    logic      i_de;
    pixel_t    i_pixel;
    logic      o_de;
    pixel_t    o_pixel;

    logic [19:0] cases_mem [MAX_RECS*REC_W];
    logic [19:0] exp_q [$];         // {de, pixel} still in flight
    int          due_q [$];
    int          cyc_n;
    int          run_cycles;
    int          cycle_limit;
    int          cur_test;
    int          checks;
    int          errors;
    int          t_checks;
    int          t_errors;

    colseg_top u_dut (
        .post_clk  (post_clk),
        .sys_rst_n (sys_rst_n),
        .i_wb_cyc  (i_wb_cyc),
        .i_wb_stb  (i_wb_stb),
        .i_wb_we   (i_wb_we),
        .i_wb_adr  (i_wb_adr),
        .i_wb_dat  (i_wb_dat),
        .o_wb_dat  (o_wb_dat),
        .o_wb_ack  (o_wb_ack),
        .i_vs      (i_vs),
        .i_de      (i_de),
        .i_pixel   (i_pixel),
        .o_de      (o_de),
        .o_pixel   (o_pixel)
    );

    initial post_clk = 1'b0;
    always #2 post_clk = ~post_clk;

    always @(posedge post_clk) begin
        run_cycles = run_cycles + 1;
        if (cycle_limit > 0 && run_cycles >= cycle_limit) begin
            $display("timeout: run still going after %0d cycles", cycle_limit);
            $display("TEST FAIL");
            $finish;
        end
    end

    function automatic string test_name(input int id);
        case (id)
            1:       return "reset_defaults";
            2:       return "raw_view";
            3:       return "class_a_mask";
            4:       return "class_b_mask";
            5:       return "erode_keep";
            6:       return "vs_clear";
            default: return "unknown";
        endcase
    endfunction

    task automatic check(input string name, input logic [19:0] expected,
                         input logic [19:0] actual);
        checks++;
        t_checks++;
        if (actual !== expected) begin
            errors++;
            t_errors++;
            $display("[FAIL] %s expected %05h actual %05h", name, expected, actual);
        end
    endtask

    // one falling edge, compare the output that is due now
    task automatic next_cycle();
        @(negedge post_clk);
        cyc_n++;
        if (due_q.size() > 0 && due_q[0] == cyc_n) begin
            check(test_name(cur_test), exp_q[0], 20'({o_de, o_pixel}));
            void'(exp_q.pop_front());
            void'(due_q.pop_front());
        end
    endtask

    task automatic drain_pipeline();
        while (exp_q.size() > 0) begin
            next_cycle();
            i_de    = 1'b0;
            i_pixel = '0;
        end
    endtask

    task automatic bus_access(input logic we, input reg_addr_t adr, input reg_t dat,
                              input reg_t expected);
        int   waited;
        logic got;
        waited = 0;
        got    = 1'b0;
        next_cycle();
        i_wb_cyc = 1'b1;
        i_wb_stb = 1'b1;
        i_wb_we  = we;
        i_wb_adr = adr;
        i_wb_dat = dat;
        while (!got && waited < ACK_LIMIT) begin
            next_cycle();
            waited++;
            got = o_wb_ack;
        end
        if (!got) begin
            errors++;
            t_errors++;
            $display("%s: register bank gave no ack at address %0h", test_name(cur_test), adr);
        end else begin
            check(test_name(cur_test), 20'd1, 20'(waited));   // ack latency
            if (!we)
                check(test_name(cur_test), 20'(expected), 20'(o_wb_dat));
        end
        i_wb_cyc = 1'b0;
        i_wb_stb = 1'b0;
        i_wb_we  = 1'b0;
    endtask

    task automatic report_test();
        $display("test %0d %s: %0d checks, %0d errors",
                 cur_test, test_name(cur_test), t_checks, t_errors);
        t_checks = 0;
        t_errors = 0;
    endtask

    initial begin
        int          n_recs;
        int          base;
        logic [19:0] op;
        logic [19:0] fld;
        logic [19:0] dat;
        logic [19:0] exp_val;
        sys_rst_n   = 1'b0;
        i_wb_cyc    = 1'b0;
        i_wb_stb    = 1'b0;
        i_wb_we     = 1'b0;
        i_wb_adr    = '0;
        i_wb_dat    = '0;
        i_vs        = 1'b0;
        i_de        = 1'b0;
        i_pixel     = '0;
        cyc_n       = 0;
        run_cycles  = 0;
        checks      = 0;
        errors      = 0;
        t_checks    = 0;
        t_errors    = 0;

        $readmemh("bench/colseg_cases.txt", cases_mem);
        n_recs = 0;
        while (n_recs < MAX_RECS && cases_mem[n_recs*REC_W+1] !== OP_END)
            n_recs++;
        cycle_limit = n_recs * 8 + 100;
        if (n_recs == 0 || n_recs == MAX_RECS) begin
            $display("cases file holds no records or lacks the end record");
            errors++;
            n_recs = 0;
        end
        cur_test = (n_recs > 0) ? int'(cases_mem[0]) : 0;

        repeat (4) @(posedge post_clk);
        @(negedge post_clk);
        sys_rst_n = 1'b1;

        for (int i = 0; i < n_recs; i++) begin
            base    = i * REC_W;
            op      = cases_mem[base+1];
            fld     = cases_mem[base+2];
            dat     = cases_mem[base+3];
            exp_val = cases_mem[base+4];
            if (int'(cases_mem[base]) != cur_test) begin
                drain_pipeline();
                report_test();
                cur_test = int'(cases_mem[base]);
            end
            case (op)
                OP_WR: begin
                    drain_pipeline();   // config stays still under a pixel run
                    bus_access(1'b1, reg_addr_t'(fld), reg_t'(dat), '0);
                end
                OP_RD: begin
                    drain_pipeline();
                    bus_access(1'b0, reg_addr_t'(fld), '0, reg_t'(exp_val));
                end
                OP_PIX: begin
                    next_cycle();
                    i_de    = fld[0];
                    i_pixel = pixel_t'(dat);
                    exp_q.push_back(exp_val);
                    due_q.push_back(cyc_n + `COLSEG_LATENCY);
                end
                OP_VS: begin
                    next_cycle();       // vs edge gets a cycle of its own
                    i_vs    = fld[0];   // level holds until the next vs record
                    i_de    = 1'b0;
                    i_pixel = '0;
                end
                default: begin
                    errors++;
                    t_errors++;
                    $display("record %0d has unknown op %0h", i, op);
                end
            endcase
        end
        drain_pipeline();
        if (n_recs > 0)
            report_test();

        $display("total: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

//--- include/colseg_defines.svh
`ifndef COLSEG_DEFINES_SVH
`define COLSEG_DEFINES_SVH

`define COLSEG_PIX_W    16
`define COLSEG_CH_W     6
`define COLSEG_REG_W    8
`define COLSEG_ADR_W    4

// class A register map
`define REG_A_R         4'd0
`define REG_A_G         4'd1
`define REG_A_B         4'd2
`define REG_A_ERR       4'd3
`define REG_A_VMIN      4'd4
`define REG_A_VMAX      4'd5

// class B register map
`define REG_B_R         4'd6
`define REG_B_G         4'd7
`define REG_B_B         4'd8
`define REG_B_ERR       4'd9
`define REG_B_VMIN      4'd10
`define REG_B_VMAX      4'd11

`define REG_ERODE_MIN   4'd12
`define REG_VIEW        4'd13
`define REG_CLASS_EN    4'd14

`define RST_A_R         8'h3E   // red reference
`define RST_A_G         8'h00
`define RST_A_B         8'h00
`define RST_A_ERR       8'h08
`define RST_A_VMIN      8'h10
`define RST_A_VMAX      8'h3F
`define RST_B_R         8'h00
`define RST_B_G         8'h00
`define RST_B_B         8'h3E   // blue reference
`define RST_B_ERR       8'h08
`define RST_B_VMIN      8'h10
`define RST_B_VMAX      8'h3F
`define RST_ERODE_MIN   8'h01
`define RST_VIEW        8'h00   // raw view
`define RST_CLASS_EN    8'h00   // both classes off

`define COLSEG_LATENCY  4

`endif

//--- list.f
+incdir+include
logic/colseg_pkg.sv
logic/sfr_bank.sv
logic/color_match.sv
logic/mask_erode.sv
logic/view_mux.sv
logic/colseg_top.sv
bench/tb_colseg.sv

//--- logic/color_match.sv
`timescale 1ns/1ns

module color_match (
    input  logic               post_clk,
    input  logic               sys_rst_n,
    input  logic               i_vs,
    input  logic               i_de,
    input  colseg_pkg::pixel_t i_pixel,
    input  colseg_pkg::chan_t  i_a_r,
    input  colseg_pkg::chan_t  i_a_g,
    input  colseg_pkg::chan_t  i_a_b,
    input  colseg_pkg::reg_t   i_a_err,
    input  colseg_pkg::reg_t   i_a_vmin,
    input  colseg_pkg::reg_t   i_a_vmax,
    input  colseg_pkg::chan_t  i_b_r,
    input  colseg_pkg::chan_t  i_b_g,
    input  colseg_pkg::chan_t  i_b_b,
    input  colseg_pkg::reg_t   i_b_err,
    input  colseg_pkg::reg_t   i_b_vmin,
    input  colseg_pkg::reg_t   i_b_vmax,
    input  logic [1:0]         i_class_en,
    output logic               o_de,
    output colseg_pkg::pixel_t o_pixel,
    output logic               o_match
);
    import colseg_pkg::*;

    logic   de1;
    pixel_t pix1;
    chan_t  r1;
    chan_t  g1;
    chan_t  b1;
    logic   hit_a;
    logic   hit_b;

    function automatic chan_t chan_diff(input chan_t a, input chan_t b);
        chan_diff = (a > b) ? a - b : b - a;
    endfunction

    // distance per channel plus brightness window on the peak channel
    function automatic logic class_hit(
        input chan_t r,
        input chan_t g,
        input chan_t b,
        input chan_t ref_r,
        input chan_t ref_g,
        input chan_t ref_b,
        input reg_t  err,
        input reg_t  vmin,
        input reg_t  vmax
    );
        chan_t peak;
        peak = (r > g) ? r : g;
        if (b > peak)
            peak = b;
        class_hit = (reg_t'(chan_diff(r, ref_r)) <= err) &&
                    (reg_t'(chan_diff(g, ref_g)) <= err) &&
                    (reg_t'(chan_diff(b, ref_b)) <= err) &&
                    (reg_t'(peak) >= vmin) && (reg_t'(peak) <= vmax);
    endfunction

    always_ff @(posedge post_clk) begin
        r1   <= {i_pixel[15:11], 1'b0};   // 5 bit red to 6
        g1   <= i_pixel[10:5];
        b1   <= {i_pixel[4:0], 1'b0};
        pix1 <= i_pixel;
        o_pixel <= pix1;
    end

    assign hit_a = i_class_en[0] &&
                   class_hit(r1, g1, b1, i_a_r, i_a_g, i_a_b, i_a_err, i_a_vmin, i_a_vmax);
    assign hit_b = i_class_en[1] &&
                   class_hit(r1, g1, b1, i_b_r, i_b_g, i_b_b, i_b_err, i_b_vmin, i_b_vmax);

    always_ff @(posedge post_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            de1     <= 1'b0;
            o_de    <= 1'b0;
            o_match <= 1'b0;
        end else if (i_vs) begin
            de1     <= 1'b0;
            o_de    <= 1'b0;
            o_match <= 1'b0;
        end else begin
            de1     <= i_de;
            o_de    <= de1;
            o_match <= de1 && (hit_a || hit_b);
        end
    end

endmodule

//--- logic/colseg_pkg.sv
`include "colseg_defines.svh"

package colseg_pkg;

    typedef logic [`COLSEG_PIX_W-1:0] pixel_t;   // rgb565
    typedef logic [`COLSEG_CH_W-1:0]  chan_t;    // channel widened to 6 bits
    typedef logic [`COLSEG_REG_W-1:0] reg_t;
    typedef logic [`COLSEG_ADR_W-1:0] reg_addr_t;

    // code 3 is shown as raw
    typedef enum logic [1:0] {
        VIEW_RAW  = 2'd0,
        VIEW_MASK = 2'd1,
        VIEW_KEEP = 2'd2
    } view_e;

    typedef enum logic {
        WB_IDLE,
        WB_ACK
    } wb_state_e;

endpackage

//--- logic/colseg_top.sv
`timescale 1ns/1ns

module colseg_top (
    input  logic                  post_clk,
    input  logic                  sys_rst_n,
    input  logic                  i_wb_cyc,
    input  logic                  i_wb_stb,
    input  logic                  i_wb_we,
    input  colseg_pkg::reg_addr_t i_wb_adr,
    input  colseg_pkg::reg_t      i_wb_dat,
    output colseg_pkg::reg_t      o_wb_dat,
    output logic                  o_wb_ack,
    input  logic                  i_vs,
    input  logic                  i_de,
    input  colseg_pkg::pixel_t    i_pixel,
    output logic                  o_de,
    output colseg_pkg::pixel_t    o_pixel
);
    import colseg_pkg::*;

    chan_t      a_r, a_g, a_b, b_r, b_g, b_b;
    reg_t       a_err, a_vmin, a_vmax, b_err, b_vmin, b_vmax;
    reg_t       erode_min;
    view_e      view;
    logic [1:0] class_en;

    logic       cm_de, cm_match, er_de, er_keep;
    pixel_t     cm_pixel, er_pixel;

    sfr_bank u_sfr_bank (
        .post_clk   (post_clk),
        .sys_rst_n  (sys_rst_n),
        .i_wb_cyc   (i_wb_cyc),
        .i_wb_stb   (i_wb_stb),
        .i_wb_we    (i_wb_we),
        .i_wb_adr   (i_wb_adr),
        .i_wb_dat   (i_wb_dat),
        .o_wb_dat   (o_wb_dat),
        .o_wb_ack   (o_wb_ack),
        .o_a_r(a_r), .o_a_g(a_g), .o_a_b(a_b),
        .o_a_err(a_err), .o_a_vmin(a_vmin), .o_a_vmax(a_vmax),
        .o_b_r(b_r), .o_b_g(b_g), .o_b_b(b_b),
        .o_b_err(b_err), .o_b_vmin(b_vmin), .o_b_vmax(b_vmax),
        .o_erode_min(erode_min),
        .o_view     (view),
        .o_class_en (class_en)
    );

    // 2 cycles
    color_match u_color_match (
        .post_clk   (post_clk),
        .sys_rst_n  (sys_rst_n),
        .i_vs       (i_vs),
        .i_de       (i_de),
        .i_pixel    (i_pixel),
        .i_a_r(a_r), .i_a_g(a_g), .i_a_b(a_b),
        .i_a_err(a_err), .i_a_vmin(a_vmin), .i_a_vmax(a_vmax),
        .i_b_r(b_r), .i_b_g(b_g), .i_b_b(b_b),
        .i_b_err(b_err), .i_b_vmin(b_vmin), .i_b_vmax(b_vmax),
        .i_class_en (class_en),
        .o_de       (cm_de),
        .o_pixel    (cm_pixel),
        .o_match    (cm_match)
    );

    mask_erode u_mask_erode (
        .post_clk   (post_clk),
        .sys_rst_n  (sys_rst_n),
        .i_vs       (i_vs),
        .i_de       (cm_de),
        .i_pixel    (cm_pixel),
        .i_match    (cm_match),
        .i_erode_min(erode_min),
        .o_de       (er_de),
        .o_pixel    (er_pixel),
        .o_keep     (er_keep)
    );

    view_mux u_view_mux (
        .post_clk   (post_clk),
        .sys_rst_n  (sys_rst_n),
        .i_vs       (i_vs),
        .i_de       (er_de),
        .i_pixel    (er_pixel),
        .i_keep     (er_keep),
        .i_view     (view),
        .o_de       (o_de),
        .o_pixel    (o_pixel)
    );

endmodule

//--- logic/mask_erode.sv
`timescale 1ns/1ns

module mask_erode (
    input  logic               post_clk,
    input  logic               sys_rst_n,
    input  logic               i_vs,
    input  logic               i_de,
    input  colseg_pkg::pixel_t i_pixel,
    input  logic               i_match,
    input  colseg_pkg::reg_t   i_erode_min,
    output logic               o_de,
    output colseg_pkg::pixel_t o_pixel,
    output logic               o_keep
);
    import colseg_pkg::*;

    // centre tap is the delayed pixel, the live input is its right neighbour
    pixel_t     c_pixel;
    logic       c_de;
    logic       c_match;
    logic       p_match;
    logic [1:0] hits;

    always_ff @(posedge post_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            c_de    <= 1'b0;
            c_match <= 1'b0;
            p_match <= 1'b0;
        end else if (i_vs) begin   // blanking wipes the history
            c_de    <= 1'b0;
            c_match <= 1'b0;
            p_match <= 1'b0;
        end else begin
            c_de    <= i_de;
            c_match <= i_de && i_match;   // de folded into the mask bit
            p_match <= c_match;
        end
    end

    always_ff @(posedge post_clk) begin
        c_pixel <= i_pixel;
    end

    assign hits = {1'b0, p_match} + {1'b0, c_match} + {1'b0, i_de && i_match};

    // min of 0 or 1 leaves the mask as it is
    assign o_keep  = c_match && (reg_t'(hits) >= i_erode_min);
    assign o_de    = c_de;
    assign o_pixel = c_pixel;

endmodule

//--- logic/sfr_bank.sv
`timescale 1ns/1ns
`include "colseg_defines.svh"

module sfr_bank (
    input  logic                  post_clk,
    input  logic                  sys_rst_n,
    input  logic                  i_wb_cyc,
    input  logic                  i_wb_stb,
    input  logic                  i_wb_we,
    input  colseg_pkg::reg_addr_t i_wb_adr,
    input  colseg_pkg::reg_t      i_wb_dat,
    output colseg_pkg::reg_t      o_wb_dat,
    output logic                  o_wb_ack,
    output colseg_pkg::chan_t     o_a_r,
    output colseg_pkg::chan_t     o_a_g,
    output colseg_pkg::chan_t     o_a_b,
    output colseg_pkg::reg_t      o_a_err,
    output colseg_pkg::reg_t      o_a_vmin,
    output colseg_pkg::reg_t      o_a_vmax,
    output colseg_pkg::chan_t     o_b_r,
    output colseg_pkg::chan_t     o_b_g,
    output colseg_pkg::chan_t     o_b_b,
    output colseg_pkg::reg_t      o_b_err,
    output colseg_pkg::reg_t      o_b_vmin,
    output colseg_pkg::reg_t      o_b_vmax,
    output colseg_pkg::reg_t      o_erode_min,
    output colseg_pkg::view_e     o_view,
    output logic [1:0]            o_class_en
);
    import colseg_pkg::*;

    localparam int NUM_REGS = 15;

    wb_state_e wb_state;
    reg_t      regs [NUM_REGS];
    reg_t      rd_dat;
    logic      req;

    function automatic reg_t rst_val(input int idx);
        case (idx)
            `REG_A_R:       rst_val = `RST_A_R;
            `REG_A_G:       rst_val = `RST_A_G;
            `REG_A_B:       rst_val = `RST_A_B;
            `REG_A_ERR:     rst_val = `RST_A_ERR;
            `REG_A_VMIN:    rst_val = `RST_A_VMIN;
            `REG_A_VMAX:    rst_val = `RST_A_VMAX;
            `REG_B_R:       rst_val = `RST_B_R;
            `REG_B_G:       rst_val = `RST_B_G;
            `REG_B_B:       rst_val = `RST_B_B;
            `REG_B_ERR:     rst_val = `RST_B_ERR;
            `REG_B_VMIN:    rst_val = `RST_B_VMIN;
            `REG_B_VMAX:    rst_val = `RST_B_VMAX;
            `REG_ERODE_MIN: rst_val = `RST_ERODE_MIN;
            `REG_VIEW:      rst_val = `RST_VIEW;
            `REG_CLASS_EN:  rst_val = `RST_CLASS_EN;
            default:        rst_val = '0;
        endcase
    endfunction

    assign req = i_wb_cyc && i_wb_stb && (wb_state == WB_IDLE);

    // one ack per strobe, then wait for stb to drop
    always_ff @(posedge post_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            wb_state <= WB_IDLE;
            o_wb_ack <= 1'b0;
        end else begin
            case (wb_state)
                WB_IDLE: begin
                    if (i_wb_cyc && i_wb_stb) begin
                        wb_state <= WB_ACK;
                        o_wb_ack <= 1'b1;
                    end
                end
                WB_ACK: begin
                    o_wb_ack <= 1'b0;
                    if (!i_wb_stb)
                        wb_state <= WB_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge post_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= rst_val(i);
        end else if (req && i_wb_we) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                if (i_wb_adr == reg_addr_t'(i))
                    regs[i] <= i_wb_dat;   // address 15 falls through
            end
        end
    end

    always_comb begin
        rd_dat = '0;
        for (int i = 0; i < NUM_REGS; i++) begin
            if (i_wb_adr == reg_addr_t'(i))
                rd_dat = regs[i];
        end
    end

    always_ff @(posedge post_clk) begin
        if (req && !i_wb_we)
            o_wb_dat <= rd_dat;
    end

    assign o_a_r       = regs[`REG_A_R][`COLSEG_CH_W-1:0];
    assign o_a_g       = regs[`REG_A_G][`COLSEG_CH_W-1:0];
    assign o_a_b       = regs[`REG_A_B][`COLSEG_CH_W-1:0];
    assign o_a_err     = regs[`REG_A_ERR];
    assign o_a_vmin    = regs[`REG_A_VMIN];
    assign o_a_vmax    = regs[`REG_A_VMAX];
    assign o_b_r       = regs[`REG_B_R][`COLSEG_CH_W-1:0];
    assign o_b_g       = regs[`REG_B_G][`COLSEG_CH_W-1:0];
    assign o_b_b       = regs[`REG_B_B][`COLSEG_CH_W-1:0];
    assign o_b_err     = regs[`REG_B_ERR];
    assign o_b_vmin    = regs[`REG_B_VMIN];
    assign o_b_vmax    = regs[`REG_B_VMAX];
    assign o_erode_min = regs[`REG_ERODE_MIN];
    assign o_view      = view_e'(regs[`REG_VIEW][1:0]);
    assign o_class_en  = regs[`REG_CLASS_EN][1:0];   // bit0 class A, bit1 class B

    a_ack_needs_req: assert property (@(posedge post_clk) disable iff (!sys_rst_n)
        $rose(o_wb_ack) |-> $past(i_wb_cyc && i_wb_stb));

endmodule

//--- logic/view_mux.sv
`timescale 1ns/1ns

module view_mux (
    input  logic               post_clk,
    input  logic               sys_rst_n,
    input  logic               i_vs,
    input  logic               i_de,
    input  colseg_pkg::pixel_t i_pixel,
    input  logic               i_keep,
    input  colseg_pkg::view_e  i_view,
    output logic               o_de,
    output colseg_pkg::pixel_t o_pixel
);
    import colseg_pkg::*;

    pixel_t view_pix;
    logic   live;

    assign live = i_de && !i_vs;

    always_comb begin
        case (i_view)
            VIEW_MASK: view_pix = i_keep ? '1 : '0;   // white on black
            VIEW_KEEP: view_pix = i_keep ? i_pixel : '0;
            default:   view_pix = i_pixel;            // raw, also code 3
        endcase
    end

    always_ff @(posedge post_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            o_de    <= 1'b0;
            o_pixel <= '0;
        end else begin
            o_de    <= live;
            o_pixel <= live ? view_pix : '0;
        end
    end

    a_vs_blanks_de: assert property (@(posedge post_clk) disable iff (!sys_rst_n)
        i_vs |=> !o_de);

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
    -f list.f --top-module tb_colseg \
    && ./obj_dir/Vtb_colseg | tee sim.log \
    || echo "build or simulation returned an error"

grep -q "^TEST PASS$" sim.log && echo "simulation passed" && exit 0 \
    || { echo "simulation failed"; exit 1; }
